/* common/dbg_mon_pkg.sv */
/*
  Shared definitions for the debug-entry monitor.
  Opcodes are full 32-bit encodings and are matched without masking.
  debug_cause_e follows the dcsr.cause encoding of the RISC-V debug spec.
  Only causes 1 to 4 are modelled; resethaltreq is not tracked.
*/

package dbg_mon_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------

  // Data and address width of the core
  localparam int XLEN = 32;

  // Encoded widths of the class and cause fields
  localparam int CLASS_W = 3;
  localparam int CAUSE_W = 3;

  // --------------------------------------------------------------------------
  // Instruction encodings
  // --------------------------------------------------------------------------

  localparam logic [XLEN-1:0] EBREAK_OPCODE  = 32'h0010_0073;
  localparam logic [XLEN-1:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [XLEN-1:0] WFI_OPCODE     = 32'h1050_0073;
  localparam logic [XLEN-1:0] DRET_OPCODE    = 32'h7B20_0073;

  // Instruction length in bytes; compressed when instr[1:0] != 2'b11
  localparam logic [XLEN-1:0] INSTR_LEN_FULL = 32'd4;
  localparam logic [XLEN-1:0] INSTR_LEN_COMP = 32'd2;

  // --------------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------------

  // Class of a retired instruction
  typedef enum logic [CLASS_W-1:0] {
    CLASS_OTHER   = 3'd0,
    CLASS_EBREAK  = 3'd1,
    CLASS_CEBREAK = 3'd2,
    CLASS_WFI     = 3'd3,
    CLASS_DRET    = 3'd4
  } instr_class_e;

  // Debug entry cause, same values as dcsr.cause
  typedef enum logic [CAUSE_W-1:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } debug_cause_e;

endpackage

/* source/wb_retire_decode.sv */
/*
  Input stage. Registers one event per cycle from the writeback port.
  A retirement with a bus error is dropped and cannot hit a trigger.
  PC fields carry no reset; read them only while ev_valid_o is high.
*/

`timescale 1ns/1ns

module wb_retire_decode (
  input  logic                                cov_assert_if,
  input  logic                                reset_i,
  input  logic                                wb_valid_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]        wb_instr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]        wb_pc_i,
  input  logic                                wb_err_i,
  input  logic                                debug_mode_i,
  input  logic                                debug_req_i,
  input  logic                                dcsr_step_i,
  input  logic                                dcsr_ebreakm_i,
  input  logic                                trig_enable_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]        tdata2_i,
  output logic                                ev_valid_o,
  output dbg_mon_pkg::instr_class_e           ev_class_o,
  output logic [dbg_mon_pkg::XLEN-1:0]        ev_pc_o,
  output logic [dbg_mon_pkg::XLEN-1:0]        ev_next_pc_o,
  output logic                                ev_trigger_o,
  output logic                                ev_dmode_o,
  output logic                                ev_req_o,
  output logic                                ev_step_o,
  output logic                                ev_ebreakm_o
);

  dbg_mon_pkg::instr_class_e         instr_class;
  logic [dbg_mon_pkg::XLEN-1:0]      instr_len;
  logic                              retire_ok;
  logic                              trig_hit;

  // Full-word compare against the known system opcodes
  always_comb begin
    case (wb_instr_i)
      dbg_mon_pkg::EBREAK_OPCODE:  instr_class = dbg_mon_pkg::CLASS_EBREAK;
      dbg_mon_pkg::CEBREAK_OPCODE: instr_class = dbg_mon_pkg::CLASS_CEBREAK;
      dbg_mon_pkg::WFI_OPCODE:     instr_class = dbg_mon_pkg::CLASS_WFI;
      dbg_mon_pkg::DRET_OPCODE:    instr_class = dbg_mon_pkg::CLASS_DRET;
      default:                     instr_class = dbg_mon_pkg::CLASS_OTHER;
    endcase
  end

  assign instr_len = (wb_instr_i[1:0] == 2'b11) ? dbg_mon_pkg::INSTR_LEN_FULL
                                                : dbg_mon_pkg::INSTR_LEN_COMP;
  assign retire_ok = wb_valid_i && !wb_err_i;
  assign trig_hit  = retire_ok && trig_enable_i && (wb_pc_i == tdata2_i);

  // Event register, control bits cleared on reset
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      ev_valid_o   <= 1'b0;
      ev_class_o   <= dbg_mon_pkg::CLASS_OTHER;
      ev_trigger_o <= 1'b0;
      ev_dmode_o   <= 1'b0;
      ev_req_o     <= 1'b0;
      ev_step_o    <= 1'b0;
      ev_ebreakm_o <= 1'b0;
    end else begin
      ev_valid_o   <= retire_ok;
      ev_class_o   <= instr_class;
      ev_trigger_o <= trig_hit;
      ev_dmode_o   <= debug_mode_i;
      ev_req_o     <= debug_req_i;
      ev_step_o    <= dcsr_step_i;
      ev_ebreakm_o <= dcsr_ebreakm_i;
    end
  end

  // PC payload
  always_ff @(posedge cov_assert_if) begin
    ev_pc_o      <= wb_pc_i;
    ev_next_pc_o <= wb_pc_i + instr_len;
  end

endmodule

/* source/debug_cause_tracker.sv */
/*
  Tracks the debug cause that should be reported on the next entry.
  Priority is trigger, ebreak (with ebreakm), haltreq, then single step.
  The cause is frozen while the event stage reports debug mode.
*/

`timescale 1ns/1ns

module debug_cause_tracker (
  input  logic                        cov_assert_if,
  input  logic                        reset_i,
  input  logic                        ev_valid_i,
  input  dbg_mon_pkg::instr_class_e   ev_class_i,
  input  logic                        ev_trigger_i,
  input  logic                        ev_dmode_i,
  input  logic                        ev_req_i,
  input  logic                        ev_step_i,
  input  logic                        ev_ebreakm_i,
  output dbg_mon_pkg::debug_cause_e   cause_o
);

  logic is_brk;
  logic step_ok;

  // Either form of ebreak that actually retired
  assign is_brk = ev_valid_i &&
                  ((ev_class_i == dbg_mon_pkg::CLASS_EBREAK) ||
                   (ev_class_i == dbg_mon_pkg::CLASS_CEBREAK));

  // Step does not override an already pending higher cause
  assign step_ok = (cause_o == dbg_mon_pkg::CAUSE_NONE) ||
                   (cause_o == dbg_mon_pkg::CAUSE_STEP);

  // --------------------------------------------------------------------------
  // Priority update
  // --------------------------------------------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      cause_o <= dbg_mon_pkg::CAUSE_NONE;
    end else if (!ev_dmode_i) begin
      if (ev_trigger_i) begin
        cause_o <= dbg_mon_pkg::CAUSE_TRIGGER;
      end else if (is_brk && ev_ebreakm_i) begin
        cause_o <= dbg_mon_pkg::CAUSE_EBREAK;
      end else if (ev_req_i) begin
        cause_o <= dbg_mon_pkg::CAUSE_HALTREQ;
      end else if (ev_step_i && step_ok) begin
        cause_o <= dbg_mon_pkg::CAUSE_STEP;
      end else if (ev_valid_i) begin
        // Plain retirement, nothing pending any more
        cause_o <= dbg_mon_pkg::CAUSE_NONE;
      end
    end
  end

endmodule

/* source/dpc_predictor.sv */
/*
  Predicts dpc and records the PC of the most recent ebreak.
  Trigger and ebreak entries report the instruction's own PC,
  everything else reports the next sequential PC.
  Interrupt and NMI redirection are not modelled.
*/

`timescale 1ns/1ns

module dpc_predictor (
  input  logic                          cov_assert_if,
  input  logic                          reset_i,
  input  logic                          ev_valid_i,
  input  dbg_mon_pkg::instr_class_e     ev_class_i,
  input  logic                          ev_trigger_i,
  input  logic                          ev_dmode_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  ev_pc_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  ev_next_pc_i,
  output logic [dbg_mon_pkg::XLEN-1:0]  dpc_o,
  output logic [dbg_mon_pkg::XLEN-1:0]  ebreak_pc_o
);

  logic is_brk;
  logic own_pc;

  assign is_brk = (ev_class_i == dbg_mon_pkg::CLASS_EBREAK) ||
                  (ev_class_i == dbg_mon_pkg::CLASS_CEBREAK);

  // Entry happens before these instructions complete
  assign own_pc = ev_trigger_i || is_brk;

  // dpc only moves on retirements outside debug mode
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      dpc_o <= '0;
    end else if (ev_valid_i && !ev_dmode_i) begin
      dpc_o <= own_pc ? ev_pc_i : ev_next_pc_i;
    end
  end

  // Any retired ebreak, debug mode included
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      ebreak_pc_o <= '0;
    end else if (ev_valid_i && is_brk) begin
      ebreak_pc_o <= ev_pc_i;
    end
  end

endmodule

/* source/debug_entry_observer.sv */
/*
  Output stage. Flags the first retirement in each stay in debug mode
  and captures the predicted cause and dpc at that point.
  Also follows WFI sleep; an interrupt or a debug request wakes the core.
*/

`timescale 1ns/1ns

module debug_entry_observer (
  input  logic                          cov_assert_if,
  input  logic                          reset_i,
  input  logic                          ev_valid_i,
  input  dbg_mon_pkg::instr_class_e     ev_class_i,
  input  logic                          ev_dmode_i,
  input  logic                          ev_req_i,
  input  logic                          ev_step_i,
  input  logic                          pending_irq_i,
  input  dbg_mon_pkg::debug_cause_e     cause_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  dpc_i,
  output logic                          first_debug_o,
  output dbg_mon_pkg::debug_cause_e     entry_cause_o,
  output logic [dbg_mon_pkg::XLEN-1:0]  entry_dpc_o,
  output logic                          in_wfi_o
);

  logic armed;
  logic entry_hit;
  logic irq_q;
  logic wfi_set;
  logic wfi_clr;

  assign entry_hit = ev_valid_i && ev_dmode_i && armed;

  // --------------------------------------------------------------------------
  // First debug-mode retirement
  // --------------------------------------------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      armed         <= 1'b0;
      first_debug_o <= 1'b0;
      entry_cause_o <= dbg_mon_pkg::CAUSE_NONE;
      entry_dpc_o   <= '0;
    end else begin
      first_debug_o <= entry_hit;
      // Re-arm on every cycle spent outside debug mode
      if (!ev_dmode_i) begin
        armed <= 1'b1;
      end else if (entry_hit) begin
        armed <= 1'b0;
      end
      if (entry_hit) begin
        entry_cause_o <= cause_i;
        entry_dpc_o   <= dpc_i;
      end
    end
  end

  // --------------------------------------------------------------------------
  // WFI sleep
  // --------------------------------------------------------------------------

  // Align the interrupt with the event stage
  assign wfi_set = ev_valid_i && (ev_class_i == dbg_mon_pkg::CLASS_WFI) &&
                   !ev_dmode_i && !ev_step_i && !ev_req_i;
  assign wfi_clr = irq_q || ev_req_i;

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      irq_q    <= 1'b0;
      in_wfi_o <= 1'b0;
    end else begin
      irq_q <= pending_irq_i;
      // Wake-up wins over a new WFI in the same cycle
      if (wfi_clr) begin
        in_wfi_o <= 1'b0;
      end else if (wfi_set) begin
        in_wfi_o <= 1'b1;
      end
    end
  end

endmodule

/* source/debug_monitor_top.sv */
/*
  Debug-entry monitor top level.
  Fixed latency of 2 cycles from sampled inputs to every output.
  One retirement per wb_valid_i cycle, no back-pressure.
*/

`timescale 1ns/1ns

module debug_monitor_top (
  input  logic                          cov_assert_if,
  input  logic                          reset_i,
  input  logic                          wb_valid_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  wb_instr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  wb_pc_i,
  input  logic                          wb_err_i,
  input  logic                          debug_mode_i,
  input  logic                          debug_req_i,
  input  logic                          dcsr_step_i,
  input  logic                          dcsr_ebreakm_i,
  input  logic                          trig_enable_i,
  input  logic [dbg_mon_pkg::XLEN-1:0]  tdata2_i,
  input  logic                          pending_irq_i,
  output logic                          first_debug_o,
  output dbg_mon_pkg::debug_cause_e     entry_cause_o,
  output logic [dbg_mon_pkg::XLEN-1:0]  entry_dpc_o,
  output logic [dbg_mon_pkg::XLEN-1:0]  ebreak_pc_o,
  output logic                          in_wfi_o
);

  // Stage 1 event
  logic                          ev_valid;
  dbg_mon_pkg::instr_class_e     ev_class;
  logic [dbg_mon_pkg::XLEN-1:0]  ev_pc;
  logic [dbg_mon_pkg::XLEN-1:0]  ev_next_pc;
  logic                          ev_trigger;
  logic                          ev_dmode;
  logic                          ev_req;
  logic                          ev_step;
  logic                          ev_ebreakm;

  // Stage 2 predictions
  dbg_mon_pkg::debug_cause_e     cause;
  logic [dbg_mon_pkg::XLEN-1:0]  dpc;

  wb_retire_decode wb_retire_decode_inst (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_i),
    .wb_instr_i     (wb_instr_i),
    .wb_pc_i        (wb_pc_i),
    .wb_err_i       (wb_err_i),
    .debug_mode_i   (debug_mode_i),
    .debug_req_i    (debug_req_i),
    .dcsr_step_i    (dcsr_step_i),
    .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .trig_enable_i  (trig_enable_i),
    .tdata2_i       (tdata2_i),
    .ev_valid_o     (ev_valid),
    .ev_class_o     (ev_class),
    .ev_pc_o        (ev_pc),
    .ev_next_pc_o   (ev_next_pc),
    .ev_trigger_o   (ev_trigger),
    .ev_dmode_o     (ev_dmode),
    .ev_req_o       (ev_req),
    .ev_step_o      (ev_step),
    .ev_ebreakm_o   (ev_ebreakm)
  );

  debug_cause_tracker debug_cause_tracker_inst (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .ev_valid_i    (ev_valid),
    .ev_class_i    (ev_class),
    .ev_trigger_i  (ev_trigger),
    .ev_dmode_i    (ev_dmode),
    .ev_req_i      (ev_req),
    .ev_step_i     (ev_step),
    .ev_ebreakm_i  (ev_ebreakm),
    .cause_o       (cause)
  );

  dpc_predictor dpc_predictor_inst (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .ev_valid_i    (ev_valid),
    .ev_class_i    (ev_class),
    .ev_trigger_i  (ev_trigger),
    .ev_dmode_i    (ev_dmode),
    .ev_pc_i       (ev_pc),
    .ev_next_pc_i  (ev_next_pc),
    .dpc_o         (dpc),
    .ebreak_pc_o   (ebreak_pc_o)
  );

  debug_entry_observer debug_entry_observer_inst (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .ev_valid_i    (ev_valid),
    .ev_class_i    (ev_class),
    .ev_dmode_i    (ev_dmode),
    .ev_req_i      (ev_req),
    .ev_step_i     (ev_step),
    .pending_irq_i (pending_irq_i),
    .cause_i       (cause),
    .dpc_i         (dpc),
    .first_debug_o (first_debug_o),
    .entry_cause_o (entry_cause_o),
    .entry_dpc_o   (entry_dpc_o),
    .in_wfi_o      (in_wfi_o)
  );

endmodule

/* sim/tb_ref_model.svh */
/*
  Reference model of the debug-entry monitor, included in the testbench.
  Holds the event stage and the prediction stage as separate variables.
  Must be updated once per rising edge, before the inputs change.
*/

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  // Event stage
  logic                          m_ev_valid;
  dbg_mon_pkg::instr_class_e     m_ev_class;
  logic [dbg_mon_pkg::XLEN-1:0]  m_ev_pc;
  logic [dbg_mon_pkg::XLEN-1:0]  m_ev_next_pc;
  logic                          m_ev_trigger;
  logic                          m_ev_dmode;
  logic                          m_ev_req;
  logic                          m_ev_step;
  logic                          m_ev_ebreakm;

  // Prediction and output stage
  dbg_mon_pkg::debug_cause_e     m_cause;
  logic [dbg_mon_pkg::XLEN-1:0]  m_dpc;
  logic [dbg_mon_pkg::XLEN-1:0]  m_ebreak_pc;
  logic                          m_armed;
  logic                          m_first;
  dbg_mon_pkg::debug_cause_e     m_entry_cause;
  logic [dbg_mon_pkg::XLEN-1:0]  m_entry_dpc;
  logic                          m_irq_q;
  logic                          m_in_wfi;

  task automatic update_ref_model();
    logic                          brk;
    logic                          retire;
    logic [dbg_mon_pkg::XLEN-1:0]  len;
    dbg_mon_pkg::instr_class_e     cls;

    brk = (m_ev_class == dbg_mon_pkg::CLASS_EBREAK) ||
          (m_ev_class == dbg_mon_pkg::CLASS_CEBREAK);

    if (reset_i) begin
      m_cause       = dbg_mon_pkg::CAUSE_NONE;
      m_dpc         = '0;
      m_ebreak_pc   = '0;
      m_armed       = 1'b0;
      m_first       = 1'b0;
      m_entry_cause = dbg_mon_pkg::CAUSE_NONE;
      m_entry_dpc   = '0;
      m_irq_q       = 1'b0;
      m_in_wfi      = 1'b0;
    end else begin
      // Observer first, it reads the old cause and dpc
      m_first = m_ev_valid && m_ev_dmode && m_armed;
      if (m_first) begin
        m_entry_cause = m_cause;
        m_entry_dpc   = m_dpc;
      end
      if (!m_ev_dmode) begin
        m_armed = 1'b1;
      end else if (m_first) begin
        m_armed = 1'b0;
      end

      // Wake-up has priority over going to sleep
      if (m_irq_q || m_ev_req) begin
        m_in_wfi = 1'b0;
      end else if (m_ev_valid && (m_ev_class == dbg_mon_pkg::CLASS_WFI) &&
                   !m_ev_dmode && !m_ev_step) begin
        m_in_wfi = 1'b1;
      end
      m_irq_q = pending_irq_i;

      if (m_ev_valid && !m_ev_dmode) begin
        m_dpc = (m_ev_trigger || brk) ? m_ev_pc : m_ev_next_pc;
      end
      if (m_ev_valid && brk) begin
        m_ebreak_pc = m_ev_pc;
      end

      // Cause priority, frozen in debug mode
      if (!m_ev_dmode) begin
        if (m_ev_trigger) begin
          m_cause = dbg_mon_pkg::CAUSE_TRIGGER;
        end else if (m_ev_valid && brk && m_ev_ebreakm) begin
          m_cause = dbg_mon_pkg::CAUSE_EBREAK;
        end else if (m_ev_req) begin
          m_cause = dbg_mon_pkg::CAUSE_HALTREQ;
        end else if (m_ev_step && ((m_cause == dbg_mon_pkg::CAUSE_NONE) ||
                                   (m_cause == dbg_mon_pkg::CAUSE_STEP))) begin
          m_cause = dbg_mon_pkg::CAUSE_STEP;
        end else if (m_ev_valid) begin
          m_cause = dbg_mon_pkg::CAUSE_NONE;
        end
      end
    end

    // Event stage from the sampled inputs
    if (wb_instr_i == dbg_mon_pkg::EBREAK_OPCODE) begin
      cls = dbg_mon_pkg::CLASS_EBREAK;
    end else if (wb_instr_i == dbg_mon_pkg::CEBREAK_OPCODE) begin
      cls = dbg_mon_pkg::CLASS_CEBREAK;
    end else if (wb_instr_i == dbg_mon_pkg::WFI_OPCODE) begin
      cls = dbg_mon_pkg::CLASS_WFI;
    end else if (wb_instr_i == dbg_mon_pkg::DRET_OPCODE) begin
      cls = dbg_mon_pkg::CLASS_DRET;
    end else begin
      cls = dbg_mon_pkg::CLASS_OTHER;
    end
    len    = (wb_instr_i[1:0] == 2'b11) ? 32'd4 : 32'd2;
    retire = wb_valid_i && !wb_err_i;

    // PC payload is not reset
    m_ev_pc      = wb_pc_i;
    m_ev_next_pc = wb_pc_i + len;
    if (reset_i) begin
      m_ev_valid   = 1'b0;
      m_ev_class   = dbg_mon_pkg::CLASS_OTHER;
      m_ev_trigger = 1'b0;
      m_ev_dmode   = 1'b0;
      m_ev_req     = 1'b0;
      m_ev_step    = 1'b0;
      m_ev_ebreakm = 1'b0;
    end else begin
      m_ev_valid   = retire;
      m_ev_class   = cls;
      m_ev_trigger = retire && trig_enable_i && (wb_pc_i == tdata2_i);
      m_ev_dmode   = debug_mode_i;
      m_ev_req     = debug_req_i;
      m_ev_step    = dcsr_step_i;
      m_ev_ebreakm = dcsr_ebreakm_i;
    end
  endtask

`endif

/* sim/tb_debug_monitor.sv */
/*
  Testbench for the debug-entry monitor.
  Random stimulus from an LCG with a fixed seed, compared on every
  falling edge against the reference model in tb_ref_model.svh.
  PCs and tdata2 share a 32-byte window so that triggers hit often.
*/

`timescale 1ns/1ns

module tb_debug_monitor;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_CYCLES     = 3000;
  localparam int DRAIN_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 96;
  localparam logic [31:0] PC_BASE = 32'h0000_1000;

  logic                          cov_assert_if;
  logic                          reset_i;
  logic                          wb_valid_i;
  logic [dbg_mon_pkg::XLEN-1:0]  wb_instr_i;
  logic [dbg_mon_pkg::XLEN-1:0]  wb_pc_i;
  logic                          wb_err_i;
  logic                          debug_mode_i;
  logic                          debug_req_i;
  logic                          dcsr_step_i;
  logic                          dcsr_ebreakm_i;
  logic                          trig_enable_i;
  logic [dbg_mon_pkg::XLEN-1:0]  tdata2_i;
  logic                          pending_irq_i;
  logic                          first_debug_o;
  dbg_mon_pkg::debug_cause_e     entry_cause_o;
  logic [dbg_mon_pkg::XLEN-1:0]  entry_dpc_o;
  logic [dbg_mon_pkg::XLEN-1:0]  ebreak_pc_o;
  logic                          in_wfi_o;

  logic [31:0] lcg_state   = 32'hd52c_c380;
  logic        checks_on   = 1'b0;
  int          error_count = 0;
  int          check_count = 0;
  int          entry_count = 0;
  int          cycle_count = 0;

  `include "tb_ref_model.svh"

  debug_monitor_top debug_monitor_top_inst (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_i),
    .wb_instr_i     (wb_instr_i),
    .wb_pc_i        (wb_pc_i),
    .wb_err_i       (wb_err_i),
    .debug_mode_i   (debug_mode_i),
    .debug_req_i    (debug_req_i),
    .dcsr_step_i    (dcsr_step_i),
    .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .trig_enable_i  (trig_enable_i),
    .tdata2_i       (tdata2_i),
    .pending_irq_i  (pending_irq_i),
    .first_debug_o  (first_debug_o),
    .entry_cause_o  (entry_cause_o),
    .entry_dpc_o    (entry_dpc_o),
    .ebreak_pc_o    (ebreak_pc_o),
    .in_wfi_o       (in_wfi_o)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #(CLK_PERIOD / 2) cov_assert_if = ~cov_assert_if;
  end

  // Callers use the upper bits since the low LCG bits have short periods
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic drive_random_inputs();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;

    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    wb_valid_i <= (r0[31:30] != 2'b00);
    wb_err_i   <= (r0[29:26] == 4'h0);
    case (r0[25:23])
      3'd0:    wb_instr_i <= dbg_mon_pkg::EBREAK_OPCODE;
      3'd1:    wb_instr_i <= dbg_mon_pkg::CEBREAK_OPCODE;
      3'd2:    wb_instr_i <= dbg_mon_pkg::WFI_OPCODE;
      3'd3:    wb_instr_i <= dbg_mon_pkg::DRET_OPCODE;
      default: wb_instr_i <= {r1[31:16], r2[31:16]};
    endcase
    wb_pc_i  <= PC_BASE + {27'd0, r0[22:19], 1'b0};
    tdata2_i <= PC_BASE + {27'd0, r3[31:28], 1'b0};
    // Rare toggles give runs in and out of debug mode
    if (r0[18:15] == 4'h0) begin
      debug_mode_i <= !debug_mode_i;
    end
    debug_req_i    <= (r3[27:24] == 4'h0);
    dcsr_step_i    <= (r3[23:21] == 3'd0);
    dcsr_ebreakm_i <= r3[20];
    trig_enable_i  <= r3[19];
    pending_irq_i  <= (r3[18:16] == 3'd0);
  endtask

  task automatic compare_outputs();
    check_count++;
    if (first_debug_o !== m_first) begin
      error_count++;
      $display("FAILED first_debug_o expected %h actual %h", m_first, first_debug_o);
    end
    if (entry_cause_o !== m_entry_cause) begin
      error_count++;
      $display("FAILED entry_cause_o expected %h actual %h", m_entry_cause, entry_cause_o);
    end
    if (entry_dpc_o !== m_entry_dpc) begin
      error_count++;
      $display("FAILED entry_dpc_o expected %h actual %h", m_entry_dpc, entry_dpc_o);
    end
    if (ebreak_pc_o !== m_ebreak_pc) begin
      error_count++;
      $display("FAILED ebreak_pc_o expected %h actual %h", m_ebreak_pc, ebreak_pc_o);
    end
    if (in_wfi_o !== m_in_wfi) begin
      error_count++;
      $display("FAILED in_wfi_o expected %h actual %h", m_in_wfi, in_wfi_o);
    end
  endtask

  // Model samples the same input values as the DUT on each edge
  always @(posedge cov_assert_if) begin
    update_ref_model();
  end

  always @(negedge cov_assert_if) begin
    if (checks_on) begin
      compare_outputs();
      if (m_first) begin
        entry_count++;
      end
    end
  end

  always @(posedge cov_assert_if) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    reset_i        = 1'b1;
    wb_valid_i     = 1'b0;
    wb_instr_i     = '0;
    wb_pc_i        = PC_BASE;
    wb_err_i       = 1'b0;
    debug_mode_i   = 1'b0;
    debug_req_i    = 1'b0;
    dcsr_step_i    = 1'b0;
    dcsr_ebreakm_i = 1'b0;
    trig_enable_i  = 1'b0;
    tdata2_i       = '0;
    pending_irq_i  = 1'b0;

    repeat (RESET_CYCLES) @(posedge cov_assert_if);
    reset_i   <= 1'b0;
    checks_on <= 1'b1;

    repeat (NUM_CYCLES) begin
      @(posedge cov_assert_if);
      drive_random_inputs();
    end

    // Let the last events leave the pipeline
    @(posedge cov_assert_if);
    wb_valid_i <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    // The last compare ran on the falling edge before this one
    @(posedge cov_assert_if);

    if (entry_count == 0) begin
      error_count++;
      $display("No debug entry was seen during the whole run");
    end
    $display("Checks: %0d  debug entries: %0d  errors: %0d",
             check_count, entry_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+sim
common/dbg_mon_pkg.sv
source/wb_retire_decode.sv
source/debug_cause_tracker.sv
source/dpc_predictor.sv
source/debug_entry_observer.sv
source/debug_monitor_top.sv
sim/tb_debug_monitor.sv

/* Bender.yml */
package:
  name: debug_monitor

sources:
  - common/dbg_mon_pkg.sv
  - source/wb_retire_decode.sv
  - source/debug_cause_tracker.sv
  - source/dpc_predictor.sv
  - source/debug_entry_observer.sv
  - source/debug_monitor_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_debug_monitor.sv
